/* bench/tb_wb_subsys.sv */
// Self-checking testbench for the writeback subsystem top level.
// Issues one decoded instruction at a time and compares the DUT against a reference model.
module tb_wb_subsys;
  timeunit 1ns;
  timeprecision 1ps;

  import wb_pkg::*;

  localparam int TIMEOUT = 20;

  logic      clk_i;
  logic      rst_ni;
  logic      en_i;
  wb_instr_t instr_i;
  lsu_req_t  lsu_req_i;
  reg_addr_t int_raddr_i;
  reg_addr_t fp_raddr_i;
  logic      ready_o;
  logic      rf_write_o;
  logic      fp_rf_write_o;
  logic      outstanding_load_o;
  logic      outstanding_store_o;
  logic      instr_done_o;
  data_t     pc_wb_o;
  data_t     fwd_wdata_o;
  data_t     int_rdata_o;
  data_t     fp_rdata_o;
  counter_t  instret_o;
  counter_t  instret_compressed_o;

  // Reference model of both files, the data memory and the retire counts
  data_t     int_m [NUM_REGS];
  data_t     fp_m [NUM_REGS];
  data_t     mem_m [MEM_WORDS];
  counter_t  ret_m;
  counter_t  ret_c_m;
  data_t     pc_next;
  data_t     held_wdata;
  logic      held_other;
  int        errors;
  int        checks;
  int        tests;
  int        seed;
  bit        aborted;

  wb_subsys_top uut (.*);

  initial clk_i = 1'b0;
  always #50 clk_i = ~clk_i;

  // Result that sits in writeback, taken at the edge where the instruction is accepted
  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      held_other <= 1'b0;
    end else if (en_i && ready_o) begin
      held_wdata <= instr_i.wdata;
      held_other <= instr_i.instr_type == WB_INSTR_OTHER;
    end
  end

  function automatic void log_fail(input string msg);
    errors++;
    $display("Fail %0t: %s", $time, msg);
  endfunction

  function automatic void check_eq(input string what, input data_t got, input data_t exp);
    checks++;
    assert (got === exp)
      else log_fail($sformatf("%s is %h, expected %h", what, got, exp));
  endfunction

  function automatic void report_test(input string name, input int e0);
    tests++;
    $display("Test %0d (%s) finished with %0d errors", tests, name, errors - e0);
  endfunction

  // Issue only stalls behind a memory access that has not answered yet
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    !ready_o |-> (outstanding_load_o || outstanding_store_o))
    else log_fail("ready_o low with no memory access outstanding");
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (outstanding_load_o || outstanding_store_o) && !instr_done_o |-> !ready_o)
    else log_fail("ready_o high while a memory access is pending");

  // The forwarding value is the held result for non-memory instructions
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    rf_write_o && held_other |-> fwd_wdata_o == held_wdata)
    else log_fail("fwd_wdata_o differs from the held result");

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    instr_done_o |=> !instr_done_o)
    else log_fail("instr_done_o stayed high for more than one cycle");

  // Issues one instruction, waits for the done pulse and updates the model
  task automatic run_instr(input wb_instr_type_e kind, input mem_addr_t addr,
                           input reg_addr_t rd, input data_t val, input logic to_fp,
                           input logic rvc, input logic perf);
    wb_instr_t ins;
    lsu_req_t  req;
    int        n;
    logic      is_mem;
    logic      ok;
    logic      rf_pend;
    logic      fp_pend;
    if (!aborted) begin
      is_mem = kind != WB_INSTR_OTHER;
      ok     = !is_mem || addr < MEM_WORDS;
      // Everything but a store has a register write pending while it sits in writeback
      rf_pend = kind != WB_INSTR_STORE && !to_fp;
      fp_pend = kind != WB_INSTR_STORE && to_fp;
      ins    = '{instr_type: kind, pc: pc_next, compressed: rvc, perf_count: perf,
                 rf_we: !is_mem && !to_fp, fp_we: !is_mem && to_fp,
                 fp_load: kind == WB_INSTR_LOAD && to_fp, waddr: rd, wdata: val};
      req    = '{valid: is_mem, we: kind == WB_INSTR_STORE, addr: addr, wdata: val};
      pc_next = pc_next + (rvc ? 32'd2 : 32'd4);
      n = 0;
      @(negedge clk_i);
      while (!ready_o && n < TIMEOUT) begin
        @(negedge clk_i);
        n++;
      end
      if (!ready_o) begin
        $display("Timeout at %0t: ready_o never came back high", $time);
        aborted = 1'b1;
      end
    end
    if (!aborted) begin
      @(posedge clk_i);
      en_i      <= 1'b1;
      instr_i   <= ins;
      lsu_req_i <= req;
      @(posedge clk_i);
      en_i      <= 1'b0;
      lsu_req_i <= '0;
      // Cycles are counted from acceptance, memory flags must hold until the answer
      n = 0;
      do begin
        @(negedge clk_i);
        n++;
        if (kind == WB_INSTR_LOAD) check_eq("outstanding_load_o", data_t'(outstanding_load_o), 1);
        if (kind == WB_INSTR_STORE)
          check_eq("outstanding_store_o", data_t'(outstanding_store_o), 1);
        check_eq("rf_write_o", data_t'(rf_write_o), data_t'(rf_pend));
        check_eq("fp_rf_write_o", data_t'(fp_rf_write_o), data_t'(fp_pend));
      end while (!instr_done_o && n < TIMEOUT);
      if (!instr_done_o) begin
        $display("Timeout at %0t: instr_done_o never pulsed", $time);
        aborted = 1'b1;
      end else begin
        check_eq("done latency", n, is_mem ? 1 + int'(addr[1:0]) : 1);
        check_eq("pc_wb_o", pc_wb_o, ins.pc);
        if (!is_mem && !to_fp && rd != '0) int_m[rd] = val;
        if (!is_mem && to_fp) fp_m[rd] = val;
        if (kind == WB_INSTR_STORE && ok) mem_m[addr[MEM_IDX_W-1:0]] = val;
        if (kind == WB_INSTR_LOAD && ok && to_fp) fp_m[rd] = mem_m[addr[MEM_IDX_W-1:0]];
        if (kind == WB_INSTR_LOAD && ok && !to_fp && rd != '0)
          int_m[rd] = mem_m[addr[MEM_IDX_W-1:0]];
        // Errored accesses never retire
        if (perf && ok) begin
          ret_m++;
          if (rvc) ret_c_m++;
        end
      end
    end
  endtask

  // Points both read ports at one entry and compares on the falling edge
  task automatic read_back(input reg_addr_t rd);
    if (!aborted) begin
      @(posedge clk_i);
      int_raddr_i <= rd;
      fp_raddr_i  <= rd;
      @(negedge clk_i);
      check_eq($sformatf("x%0d", rd), int_rdata_o, int_m[rd]);
      check_eq($sformatf("f%0d", rd), fp_rdata_o, fp_m[rd]);
    end
  endtask

  task automatic check_state();
    for (int i = 0; i < NUM_REGS; i++) begin
      read_back(reg_addr_t'(i));
    end
    check_eq("instret_o", instret_o, ret_m);
    check_eq("instret_compressed_o", instret_compressed_o, ret_c_m);
  endtask

  initial begin : main
    int        e0;
    int        kind;
    int        r;
    mem_addr_t addr;
    errors  = 0;
    checks  = 0;
    tests   = 0;
    aborted = 1'b0;
    seed    = 54742;
    pc_next = 32'h0000_0100;
    ret_m   = '0;
    ret_c_m = '0;
    for (int i = 0; i < NUM_REGS; i++) begin
      int_m[i] = '0;
      fp_m[i]  = '0;
    end
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem_m[i] = '0;
    end
    en_i        <= 1'b0;
    instr_i     <= '0;
    lsu_req_i   <= '0;
    int_raddr_i <= '0;
    fp_raddr_i  <= '0;
    rst_ni      <= 1'b0;
    repeat (4) @(posedge clk_i);
    rst_ni <= 1'b1;

    e0 = errors;
    @(negedge clk_i);
    check_eq("ready_o", data_t'(ready_o), 1);
    check_eq("status flags", data_t'({rf_write_o, fp_rf_write_o, outstanding_load_o,
                                      outstanding_store_o, instr_done_o}), 0);
    check_state();
    report_test("reset state", e0);

    // Entry zero is hard-wired only in the integer file
    e0 = errors;
    run_instr(WB_INSTR_OTHER, '0, 5'd3, 32'h1234_5678, 1'b0, 1'b0, 1'b1);
    read_back(5'd3);
    run_instr(WB_INSTR_OTHER, '0, 5'd3, 32'h0ace_0001, 1'b1, 1'b1, 1'b1);
    read_back(5'd3);
    run_instr(WB_INSTR_OTHER, '0, 5'd0, 32'hdead_beef, 1'b0, 1'b0, 1'b1);
    read_back(5'd0);
    run_instr(WB_INSTR_OTHER, '0, 5'd0, 32'h0bad_f00d, 1'b1, 1'b0, 1'b0);
    read_back(5'd0);
    report_test("register writes", e0);

    // Low address bits 0 to 3 cover every response latency
    e0 = errors;
    run_instr(WB_INSTR_STORE, 32'd4, '0, 32'h1111_aaaa, 1'b0, 1'b0, 1'b1);
    run_instr(WB_INSTR_STORE, 32'd9, '0, 32'h2222_bbbb, 1'b0, 1'b1, 1'b1);
    run_instr(WB_INSTR_STORE, 32'd14, '0, 32'h3333_cccc, 1'b0, 1'b0, 1'b1);
    run_instr(WB_INSTR_STORE, 32'd63, '0, 32'h4444_dddd, 1'b0, 1'b0, 1'b0);
    run_instr(WB_INSTR_LOAD, 32'd4, 5'd7, '0, 1'b0, 1'b1, 1'b1);
    read_back(5'd7);
    run_instr(WB_INSTR_LOAD, 32'd9, 5'd8, '0, 1'b1, 1'b0, 1'b1);
    read_back(5'd8);
    run_instr(WB_INSTR_LOAD, 32'd14, 5'd10, '0, 1'b0, 1'b0, 1'b1);
    run_instr(WB_INSTR_LOAD, 32'd63, 5'd11, '0, 1'b1, 1'b0, 1'b1);
    read_back(5'd10);
    read_back(5'd11);
    report_test("memory access", e0);

    // Out-of-range accesses complete but write nothing and do not retire
    e0 = errors;
    run_instr(WB_INSTR_STORE, 32'd66, '0, 32'h5555_eeee, 1'b0, 1'b1, 1'b1);
    run_instr(WB_INSTR_LOAD, 32'd65, 5'd7, '0, 1'b0, 1'b1, 1'b1);
    run_instr(WB_INSTR_LOAD, 32'h8000_0003, 5'd8, '0, 1'b1, 1'b1, 1'b1);
    read_back(5'd7);
    read_back(5'd8);
    check_eq("instret_o after errors", instret_o, ret_m);
    check_eq("instret_compressed_o after errors", instret_compressed_o, ret_c_m);
    run_instr(WB_INSTR_LOAD, 32'd2, 5'd9, '0, 1'b0, 1'b0, 1'b1);
    read_back(5'd9);
    report_test("address range error", e0);

    // Addresses up to 71 include some out-of-range words
    e0 = errors;
    for (int i = 0; i < 200; i++) begin
      kind = {$random(seed)} % 3;
      r    = $random(seed);
      addr = {$random(seed)} % 72;
      run_instr(kind == 0 ? WB_INSTR_OTHER : (kind == 1 ? WB_INSTR_STORE : WB_INSTR_LOAD),
                addr, reg_addr_t'(r[4:0]), $random(seed), r[5], r[6], r[7] | r[8]);
    end
    check_state();
    report_test("random mix", e0);

    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0 && !aborted) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and looks for the pass message in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_wb_subsys -f wb_subsys_top.f \
  && ./obj_dir/Vtb_wb_subsys | tee sim.log \
  && grep -qx "all tests passed" sim.log \
  && echo "Simulation result: PASS" \
  || { echo "Simulation result: FAIL"; exit 1; }

/* src/lsu_unit.sv */
// Load/store unit with a word-addressed data memory.
// Answers each request with one valid pulse after 1 + addr[1:0] cycles.
module lsu_unit (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  wb_pkg::lsu_req_t  req_i,
  output wb_pkg::lsu_resp_t resp_o
);

  import wb_pkg::*;

  data_t     mem_q [MEM_WORDS];

  // Request in flight and cycles left until the response
  logic      busy_q;
  logic [1:0] wait_q;
  logic      we_q;
  mem_addr_t addr_q;
  data_t     wdata_q;

  logic      resp_fire;
  logic      addr_err;
  logic [MEM_IDX_W-1:0] mem_idx;

  assign resp_fire = busy_q & (wait_q == 2'd0);

  // Anything outside the memory depth is flagged, upper bits included
  assign addr_err = addr_q >= mem_addr_t'(MEM_WORDS);
  assign mem_idx  = addr_q[MEM_IDX_W-1:0];

  // Control state, a new request always wins over the finishing one
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q <= 1'b0;
      wait_q <= 2'd0;
    end else begin
      if (req_i.valid) begin
        busy_q <= 1'b1;
        wait_q <= req_i.addr[1:0];
      end else if (resp_fire) begin
        busy_q <= 1'b0;
      end else if (busy_q) begin
        wait_q <= wait_q - 2'd1;
      end
    end
  end

  // Request payload
  always_ff @(posedge clk_i) begin
    if (req_i.valid) begin
      we_q    <= req_i.we;
      addr_q  <= req_i.addr;
      wdata_q <= req_i.wdata;
    end
  end

  // Memory comes out of reset cleared, stores land at the edge ending the pulse
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < MEM_WORDS; i++) begin
        mem_q[i] <= '0;
      end
    end else if (resp_fire && we_q && !addr_err) begin
      mem_q[mem_idx] <= wdata_q;
    end
  end

  assign resp_o.valid = resp_fire;
  assign resp_o.err   = resp_fire & addr_err;

  // Read data is zero for stores and for out-of-range loads
  assign resp_o.rdata = (resp_fire && !we_q && !addr_err) ? mem_q[mem_idx] : '0;

endmodule

/* src/reg_file.sv */
// Register file with one write port and one combinational read port.
// Set ZeroReg for the integer file so that entry zero is hard-wired.
module reg_file #(
  parameter bit ZeroReg = 1'b0
) (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  wb_pkg::rf_wr_t    wr_i,
  input  wb_pkg::reg_addr_t raddr_i,
  output wb_pkg::data_t     rdata_o
);

  import wb_pkg::*;

  data_t regs_q [NUM_REGS];
  logic  wr_en;
  logic  rd_zero;

  // Writes to entry zero are dropped when it is hard-wired
  assign wr_en   = wr_i.we & ~(ZeroReg & (wr_i.waddr == '0));
  assign rd_zero = ZeroReg & (raddr_i == '0);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (wr_en) begin
      regs_q[wr_i.waddr] <= wr_i.wdata;
    end
  end

  assign rdata_o = rd_zero ? '0 : regs_q[raddr_i];

endmodule

/* src/retire_counters.sv */
// Retired instruction counters driven by the writeback retire pulses.
// One counter for all retirements and one for compressed ones only.
module retire_counters (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             retire_i,
  input  logic             retire_compressed_i,
  output wb_pkg::counter_t instret_o,
  output wb_pkg::counter_t instret_compressed_o
);

  import wb_pkg::*;

  counter_t instret_q;
  counter_t instret_c_q;

  // All retired instructions
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      instret_q <= '0;
    end else if (retire_i) begin
      instret_q <= instret_q + counter_t'(1);
    end
  end

  // Compressed pulse is only raised together with the main one
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      instret_c_q <= '0;
    end else if (retire_compressed_i) begin
      instret_c_q <= instret_c_q + counter_t'(1);
    end
  end

  assign instret_o            = instret_q;
  assign instret_compressed_o = instret_c_q;

endmodule

/* src/wb_pkg.sv */
// Shared widths, types and structs for the writeback subsystem.
// Every block imports this package to agree on bus layouts.
package wb_pkg;

  // Data path and register file geometry
  localparam int unsigned XLEN       = 32;
  localparam int unsigned NUM_REGS   = 32;
  localparam int unsigned REG_ADDR_W = 5;

  // Data memory depth in words, addresses at or above this are out of range
  localparam int unsigned MEM_WORDS  = 64;
  localparam int unsigned MEM_IDX_W  = $clog2(MEM_WORDS);

  typedef logic [XLEN-1:0]       data_t;
  typedef logic [REG_ADDR_W-1:0] reg_addr_t;
  typedef logic [31:0]           mem_addr_t;
  typedef logic [31:0]           counter_t;

  // Class of the instruction sitting in writeback
  typedef enum logic [1:0] {
    WB_INSTR_LOAD  = 2'b00,
    WB_INSTR_STORE = 2'b01,
    WB_INSTR_OTHER = 2'b10
  } wb_instr_type_e;

  // Decoded instruction as handed over by the issue stage
  typedef struct packed {
    wb_instr_type_e instr_type;
    data_t          pc;
    logic           compressed;
    logic           perf_count;
    logic           rf_we;
    logic           fp_we;
    logic           fp_load;
    reg_addr_t      waddr;
    data_t          wdata;
  } wb_instr_t;

  typedef struct packed {
    logic      valid;
    logic      we;
    mem_addr_t addr;
    data_t     wdata;
  } lsu_req_t;

  typedef struct packed {
    logic  valid;
    logic  err;
    data_t rdata;
  } lsu_resp_t;

  typedef struct packed {
    logic      we;
    reg_addr_t waddr;
    data_t     wdata;
  } rf_wr_t;

endpackage

/* src/wb_stage.sv */
// Writeback stage feeding the integer and floating-point register files.
// Holds one instruction until done and reports hazards, forwarding and retirement.
// With WritebackStage cleared the instruction is passed straight to the files.
module wb_stage #(
  parameter bit WritebackStage = 1'b1
) (
  input  logic              clk_i,
  input  logic              rst_ni,

  input  logic              en_wb_i,
  input  wb_pkg::wb_instr_t instr_i,
  input  wb_pkg::lsu_resp_t lsu_resp_i,

  output logic              ready_wb_o,
  output logic              rf_write_wb_o,
  output logic              fp_rf_write_wb_o,
  output logic              outstanding_load_wb_o,
  output logic              outstanding_store_wb_o,
  output logic              instr_done_wb_o,
  output logic              perf_instr_ret_wb_o,
  output logic              perf_instr_ret_compressed_wb_o,
  output wb_pkg::data_t     pc_wb_o,
  output wb_pkg::data_t     rf_wdata_fwd_wb_o,
  output wb_pkg::rf_wr_t    int_wr_o,
  output wb_pkg::rf_wr_t    fp_wr_o
);

  import wb_pkg::*;

  // Write enables for the two sources of each file, result and load data
  logic      res_we_int;
  logic      res_we_fp;
  logic      ld_we_int;
  logic      ld_we_fp;
  data_t     res_wdata;
  reg_addr_t wr_addr;

  // An error response never retires and never writes load data
  logic      lsu_err_resp;
  logic      lsu_ok_resp;

  assign lsu_err_resp = lsu_resp_i.valid & lsu_resp_i.err;
  assign lsu_ok_resp  = lsu_resp_i.valid & ~lsu_resp_i.err;

  if (WritebackStage) begin : g_writeback_stage
    wb_instr_t instr_q;
    logic      wb_valid_q;
    logic      wb_valid_d;
    logic      wb_done;
    logic      accept;
    logic      is_load;
    logic      is_store;
    logic      is_other;

    assign is_load  = instr_q.instr_type == WB_INSTR_LOAD;
    assign is_store = instr_q.instr_type == WB_INSTR_STORE;
    assign is_other = instr_q.instr_type == WB_INSTR_OTHER;

    // Non-memory instructions finish in their first cycle, memory ones wait for the response
    assign wb_done = is_other | lsu_resp_i.valid;
    assign accept  = en_wb_i & ready_wb_o;

    // Valid sets on a new instruction and clears once the held one is done
    assign wb_valid_d = accept | (wb_valid_q & ~wb_done);

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        wb_valid_q <= 1'b0;
      end else begin
        wb_valid_q <= wb_valid_d;
      end
    end

    // Instruction payload only moves on acceptance
    always_ff @(posedge clk_i) begin
      if (accept) begin
        instr_q <= instr_i;
      end
    end

    assign ready_wb_o = ~wb_valid_q | wb_done;

    // Pending writes seen by issue for read hazard checks
    assign rf_write_wb_o    = wb_valid_q & (instr_q.rf_we | (is_load & ~instr_q.fp_load));
    assign fp_rf_write_wb_o = wb_valid_q & (instr_q.fp_we | (is_load & instr_q.fp_load));

    assign outstanding_load_wb_o  = wb_valid_q & is_load;
    assign outstanding_store_wb_o = wb_valid_q & is_store;

    assign instr_done_wb_o = wb_valid_q & wb_done;
    assign pc_wb_o         = instr_q.pc;

    // Load data arrives too late for forwarding, so only the held result goes back
    assign rf_wdata_fwd_wb_o = instr_q.wdata;

    assign res_we_int = wb_valid_q & is_other & instr_q.rf_we;
    assign res_we_fp  = wb_valid_q & is_other & instr_q.fp_we;
    assign ld_we_int  = wb_valid_q & is_load & lsu_ok_resp & ~instr_q.fp_load;
    assign ld_we_fp   = wb_valid_q & is_load & lsu_ok_resp & instr_q.fp_load;
    assign res_wdata  = instr_q.wdata;
    assign wr_addr    = instr_q.waddr;

    assign perf_instr_ret_wb_o            = instr_done_wb_o & instr_q.perf_count & ~lsu_err_resp;
    assign perf_instr_ret_compressed_wb_o = perf_instr_ret_wb_o & instr_q.compressed;
  end else begin : g_bypass_wb
    logic in_other;

    assign in_other = instr_i.instr_type == WB_INSTR_OTHER;

    // Nothing is held, so issue never stalls here and no hazard is reported
    assign ready_wb_o             = 1'b1;
    assign rf_write_wb_o          = 1'b0;
    assign fp_rf_write_wb_o       = 1'b0;
    assign outstanding_load_wb_o  = 1'b0;
    assign outstanding_store_wb_o = 1'b0;
    assign pc_wb_o                = '0;
    assign rf_wdata_fwd_wb_o      = '0;

    // Completion is the issue cycle for results and the response cycle for memory
    assign instr_done_wb_o = (en_wb_i & in_other) | lsu_resp_i.valid;

    assign res_we_int = en_wb_i & in_other & instr_i.rf_we;
    assign res_we_fp  = en_wb_i & in_other & instr_i.fp_we;
    assign ld_we_int  = lsu_ok_resp & ~instr_i.fp_load;
    assign ld_we_fp   = lsu_ok_resp & instr_i.fp_load;
    assign res_wdata  = instr_i.wdata;
    assign wr_addr    = instr_i.waddr;

    assign perf_instr_ret_wb_o            = en_wb_i & instr_i.perf_count & ~lsu_err_resp;
    assign perf_instr_ret_compressed_wb_o = perf_instr_ret_wb_o & instr_i.compressed;
  end

  // Each file takes either the held result or the load data, never both at once
  assign int_wr_o.we    = res_we_int | ld_we_int;
  assign int_wr_o.waddr = wr_addr;
  assign int_wr_o.wdata = res_we_int ? res_wdata : lsu_resp_i.rdata;

  assign fp_wr_o.we    = res_we_fp | ld_we_fp;
  assign fp_wr_o.waddr = wr_addr;
  assign fp_wr_o.wdata = res_we_fp ? res_wdata : lsu_resp_i.rdata;

endmodule

/* src/wb_subsys_top.sv */
// Top level of the writeback subsystem.
// Joins the registered writeback stage, the LSU, both register files and the counters.
module wb_subsys_top (
  input  logic              clk_i,
  input  logic              rst_ni,

  // Issue side
  input  logic              en_i,
  input  wb_pkg::wb_instr_t instr_i,
  input  wb_pkg::lsu_req_t  lsu_req_i,

  // Register read ports
  input  wb_pkg::reg_addr_t int_raddr_i,
  input  wb_pkg::reg_addr_t fp_raddr_i,

  output logic              ready_o,
  output logic              rf_write_o,
  output logic              fp_rf_write_o,
  output logic              outstanding_load_o,
  output logic              outstanding_store_o,
  output logic              instr_done_o,
  output wb_pkg::data_t     pc_wb_o,
  output wb_pkg::data_t     fwd_wdata_o,
  output wb_pkg::data_t     int_rdata_o,
  output wb_pkg::data_t     fp_rdata_o,
  output wb_pkg::counter_t  instret_o,
  output wb_pkg::counter_t  instret_compressed_o
);

  import wb_pkg::*;

  lsu_resp_t lsu_resp;
  rf_wr_t    int_wr;
  rf_wr_t    fp_wr;
  logic      retire;
  logic      retire_compressed;

  // Registered writeback form
  wb_stage #(
    .WritebackStage(1'b1)
  ) u_wb_stage (
    .clk_i                          (clk_i),
    .rst_ni                         (rst_ni),
    .en_wb_i                        (en_i),
    .instr_i                        (instr_i),
    .lsu_resp_i                     (lsu_resp),
    .ready_wb_o                     (ready_o),
    .rf_write_wb_o                  (rf_write_o),
    .fp_rf_write_wb_o               (fp_rf_write_o),
    .outstanding_load_wb_o          (outstanding_load_o),
    .outstanding_store_wb_o         (outstanding_store_o),
    .instr_done_wb_o                (instr_done_o),
    .perf_instr_ret_wb_o            (retire),
    .perf_instr_ret_compressed_wb_o (retire_compressed),
    .pc_wb_o                        (pc_wb_o),
    .rf_wdata_fwd_wb_o              (fwd_wdata_o),
    .int_wr_o                       (int_wr),
    .fp_wr_o                        (fp_wr)
  );

  lsu_unit u_lsu (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .req_i  (lsu_req_i),
    .resp_o (lsu_resp)
  );

  // Integer file keeps x0 at zero
  reg_file #(
    .ZeroReg(1'b1)
  ) u_int_rf (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .wr_i    (int_wr),
    .raddr_i (int_raddr_i),
    .rdata_o (int_rdata_o)
  );

  reg_file #(
    .ZeroReg(1'b0)
  ) u_fp_rf (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .wr_i    (fp_wr),
    .raddr_i (fp_raddr_i),
    .rdata_o (fp_rdata_o)
  );

  retire_counters u_retire_counters (
    .clk_i                (clk_i),
    .rst_ni               (rst_ni),
    .retire_i             (retire),
    .retire_compressed_i  (retire_compressed),
    .instret_o            (instret_o),
    .instret_compressed_o (instret_compressed_o)
  );

endmodule

/* wb_subsys_top.f */
src/wb_pkg.sv
src/reg_file.sv
src/retire_counters.sv
src/lsu_unit.sv
src/wb_stage.sv
src/wb_subsys_top.sv
bench/tb_wb_subsys.sv
